/* fencei_tests.txt */
# name mask0 mask1 mask2 mask3 outstanding wbuf_full wbuf_cycles pc fetch_addr ack_latency
# masks, pc and fetch_addr are hex, the other numbers decimal
empty_cache        0000 0000 0000 0000 0 0 0 00001000 00001004 2
one_line           0001 0000 0000 0000 0 0 0 00001004 00001008 2
full_bank0         ffff 0000 0000 0000 0 0 0 00002000 00002004 17
flush_cleared      0000 0000 0000 0000 0 0 0 00002004 00002008 2
uneven_fill        0003 00f0 0f0f 8000 0 0 0 00003010 00003014 9
all_full           ffff ffff ffff ffff 0 0 0 00004000 00004004 17
second_flush       0000 0000 0000 0000 0 0 0 00004008 0000400c 2
misaligned_pc1     0101 0000 0000 0000 0 0 0 00005001 00005004 3
misaligned_pc2     0000 0007 0000 0000 0 0 0 00005002 00005004 4
misaligned_pc3     0000 0000 1111 0000 0 0 0 00005003 00005004 5
wrap_top           0000 0000 0000 00ff 0 0 0 fffffffc 00000000 9
wrap_misaligned    0000 0000 0000 0000 0 0 0 ffffffff 00000000 2
bus_one_outs       0f00 0000 0000 0000 1 0 0 00006000 00006004 5
bus_four_outs      0000 3333 0000 0000 4 0 0 00006100 00006104 9
wbuf_full_3        0000 0000 0000 0001 0 1 3 00006200 00006204 2
wbuf_full_1        00ff 0000 0000 0000 0 1 1 00006300 00006304 9
bus_and_wbuf       0000 0000 ffff 0000 2 1 6 00006400 00006404 17
bus_and_wbuf_short 5555 aaaa 0000 0000 3 1 1 00006502 00006504 9
cleared_again      0000 0000 0000 0000 0 0 0 00006600 00006604 2
single_lines       0001 0002 0004 0008 2 0 0 7ffffffe 80000000 2

/* sources.f */
fencei_pkg.sv
fencei_ctrl.sv
icache_bank_flush.sv
flush_ack_merge.sv
fencei_top.sv
tb_fencei.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fence.i testbench with Verilator and runs it.
# The exit status is nonzero if the build fails or the run fails.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fencei \
  -f sources.f \
  -o tb_fencei \
  && ./obj_dir/tb_fencei \
  || { echo "simulation failed" >&2; exit 1; }

echo "simulation finished"

/* tb_fencei.sv */
// ########################################################
// Testbench for the fence.i flush path.
// Reads one scenario per line from fencei_tests.txt, fills
// the cache banks, loads the data bus and write buffer,
// then issues a fence.i and checks every cycle of the
// sequence until the instruction has retired.
// ########################################################

`timescale 1ns/1ps

module tb_fencei import fencei_pkg::*; ();

  localparam int NUM_BANKS      = DEFAULT_NUM_BANKS;
  localparam int LINES_PER_BANK = DEFAULT_LINES_PER_BANK;
  localparam int LOOP_TIMEOUT   = 200;
  localparam int MAX_TESTS      = 100;

  logic      clk_i;
  logic      rst_ni;
  logic      fencei_valid_i;
  addr_t     wb_pc_i;
  logic      data_req_i;
  logic      data_gnt_i;
  logic      data_rvalid_i;
  logic      wbuf_empty_i;
  logic      fill_valid_i;
  bank_idx_t fill_bank_i;
  line_idx_t fill_line_i;

  logic      flush_req_o;
  logic      flush_ack_o;
  logic      retire_o;
  logic      fetch_req_o;
  addr_t     fetch_addr_o;
  logic      data_block_o;
  logic      busy_o;

  // Current scenario as read from the data file
  logic [8*32-1:0] test_name;
  logic [15:0]     fill_mask [NUM_BANKS];
  int              outs_count;
  int              wbuf_full;
  int              wbuf_cycles;
  addr_t           test_pc;
  addr_t           file_fetch;
  int              file_latency;

  logic [31:0] lfsr_q;

  fencei_top dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fencei_valid_i (fencei_valid_i),
    .wb_pc_i        (wb_pc_i),
    .data_req_i     (data_req_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .wbuf_empty_i   (wbuf_empty_i),
    .fill_valid_i   (fill_valid_i),
    .fill_bank_i    (fill_bank_i),
    .fill_line_i    (fill_line_i),
    .flush_req_o    (flush_req_o),
    .flush_ack_o    (flush_ack_o),
    .retire_o       (retire_o),
    .fetch_req_o    (fetch_req_o),
    .fetch_addr_o   (fetch_addr_o),
    .data_block_o   (data_block_o),
    .busy_o         (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | lfsr_q[0];
    end
  endtask

  function automatic int count_ones(input logic [15:0] m);
    int n;
    n = 0;
    for (int i = 0; i < 16; i++) begin
      n += int'(m[i]);
    end
    return n;
  endfunction

  // Slowest bank, at least one cycle each, plus the merge cycle
  function automatic int expected_latency();
    int worst;
    int k;
    worst = 1;
    for (int b = 0; b < NUM_BANKS; b++) begin
      k = count_ones(fill_mask[b]);
      if (k > worst) begin
        worst = k;
      end
    end
    return worst + 1;
  endfunction

  function automatic addr_t expected_fetch(input addr_t pc);
    return (pc & 32'hffff_fffc) + 32'd4;
  endfunction

  task automatic stop_failed();
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch in test %0s, %0s: expected %0h, actual %0h",
               test_name, what, expected, actual);
      stop_failed();
    end
  endtask

  task automatic fill_cache();
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int i = 0; i < LINES_PER_BANK; i++) begin
        if (fill_mask[b][i]) begin
          @(posedge clk_i);
          fill_valid_i <= 1'b1;
          fill_bank_i  <= bank_idx_t'(b);
          fill_line_i  <= line_idx_t'(i);
        end
      end
    end
    @(posedge clk_i);
    fill_valid_i <= 1'b0;
  endtask

  // Granted requests with no response leave n transactions open
  task automatic make_outstanding(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      data_req_i <= 1'b1;
      data_gnt_i <= 1'b1;
    end
    @(posedge clk_i);
    data_req_i   <= 1'b0;
    data_gnt_i   <= 1'b0;
    wbuf_empty_i <= 1'b1;
  endtask

  task automatic run_fence();
    int          cyc;
    int          outs;
    int          gap;
    int          wbuf_left;
    int          idle_cyc;
    int          exp_ack;
    int          rise_cyc;
    int          ack_count;
    int          exp_lat;
    int unsigned rnd;
    addr_t       exp_fetch;
    logic        has_idle;
    logic        exp_req;
    logic        exp_ack_now;
    logic        exp_redirect;
    logic        exp_block;
    logic        exp_busy;
    logic        finished;

    exp_lat   = expected_latency();
    exp_fetch = expected_fetch(test_pc);
    outs      = outs_count;
    wbuf_left = (wbuf_full != 0) ? wbuf_cycles : 0;
    idle_cyc  = -1;
    exp_ack   = -1;
    rise_cyc  = -1;
    ack_count = 0;
    cyc       = 0;
    finished  = 1'b0;
    random_bits(2, rnd);
    gap = int'(rnd);

    // Cycle 0 presents the fence.i in writeback
    @(posedge clk_i);
    fencei_valid_i <= 1'b1;
    wb_pc_i        <= test_pc;
    wbuf_empty_i   <= (wbuf_left == 0);

    while (!finished) begin
      @(negedge clk_i);
      if (idle_cyc < 0 && outs == 0 && wbuf_empty_i) begin
        idle_cyc = cyc;
        exp_ack  = cyc + 1 + exp_lat;
      end
      has_idle     = (idle_cyc >= 0);
      exp_req      = has_idle && cyc > idle_cyc && cyc <= exp_ack;
      exp_ack_now  = has_idle && cyc == exp_ack;
      exp_redirect = has_idle && cyc == exp_ack + 1;
      exp_block    = cyc >= 1 && !(has_idle && cyc > exp_ack);
      exp_busy     = cyc >= 1 && !(has_idle && cyc > exp_ack + 1);

      if (flush_req_o && rise_cyc < 0) begin
        rise_cyc = cyc;
      end
      check_value("flush_req_o", exp_req, flush_req_o);
      if (flush_ack_o) begin
        ack_count++;
        check_value("ack latency", exp_lat, cyc - rise_cyc);
      end
      check_value("flush_ack_o", exp_ack_now, flush_ack_o);
      check_value("data_block_o", exp_block, data_block_o);
      check_value("retire_o", exp_redirect, retire_o);
      check_value("fetch_req_o", exp_redirect, fetch_req_o);
      check_value("busy_o", exp_busy, busy_o);
      if (exp_redirect) begin
        check_value("fetch_addr_o", exp_fetch, fetch_addr_o);
      end

      // Response returned this cycle
      if (data_rvalid_i && outs > 0) begin
        outs--;
      end

      if (cyc >= 1 && !busy_o) begin
        finished = 1'b1;
      end else if (cyc >= LOOP_TIMEOUT) begin
        $display("timeout in test %0s: fence.i did not retire within %0d cycles",
                 test_name, LOOP_TIMEOUT);
        stop_failed();
      end else begin
        cyc++;
        @(posedge clk_i);
        fencei_valid_i <= 1'b0;
        if (wbuf_left > 0) begin
          wbuf_left--;
        end
        wbuf_empty_i <= (wbuf_left == 0);
        if (outs > 0 && gap == 0) begin
          data_rvalid_i <= 1'b1;
          random_bits(2, rnd);
          gap = int'(rnd);
        end else begin
          data_rvalid_i <= 1'b0;
          if (gap > 0) begin
            gap--;
          end
        end
      end
    end
    check_value("flush_ack_o pulses", 1, ack_count);
  endtask

  initial begin : main
    int               fd;
    int               code;
    int               tests_run;
    int unsigned      delay;
    logic             done_reading;
    logic [8*32-1:0]  token;
    logic [8*128-1:0] rest;

    rst_ni         = 1'b0;
    fencei_valid_i = 1'b0;
    wb_pc_i        = '0;
    data_req_i     = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    wbuf_empty_i   = 1'b1;
    fill_valid_i   = 1'b0;
    fill_bank_i    = '0;
    fill_line_i    = '0;
    lfsr_q         = 32'hd2e5b99b;

    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    test_name = "reset";
    check_value("flush_req_o", 0, flush_req_o);
    check_value("retire_o", 0, retire_o);
    check_value("fetch_req_o", 0, fetch_req_o);
    check_value("data_block_o", 0, data_block_o);
    check_value("busy_o", 0, busy_o);

    fd = $fopen("fencei_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open fencei_tests.txt");
      stop_failed();
    end

    tests_run    = 0;
    done_reading = 1'b0;
    while (!done_reading) begin
      code = $fscanf(fd, "%s", token);
      if (code != 1) begin
        done_reading = 1'b1;
      end else if (token == "#") begin
        code = $fgets(rest, fd);
      end else begin
        test_name = token;
        code = $fscanf(fd, "%h %h %h %h %d %d %d %h %h %d",
                       fill_mask[0], fill_mask[1], fill_mask[2], fill_mask[3],
                       outs_count, wbuf_full, wbuf_cycles,
                       test_pc, file_fetch, file_latency);
        if (code != 10) begin
          $display("malformed line in fencei_tests.txt for test %0s", token);
          stop_failed();
        end
        check_value("file fetch address", expected_fetch(test_pc), file_fetch);
        check_value("file ack latency", expected_latency(), file_latency);
        fill_cache();
        make_outstanding(outs_count);
        random_bits(2, delay);
        repeat (delay) @(posedge clk_i);
        run_fence();
        tests_run++;
        if (tests_run >= MAX_TESTS) begin
          done_reading = 1'b1;
        end
      end
    end
    $fclose(fd);

    if (tests_run == 0) begin
      $display("no tests found in fencei_tests.txt");
      stop_failed();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* fencei_top.sv */
// ########################################################
// Top level of the fence.i flush path.
// Connects the sequencer, the cache valid banks and the
// done merge. Fill strobes are steered to one bank by the
// bank index.
// ########################################################

`timescale 1ns/1ps

module fencei_top import fencei_pkg::*; #(
  parameter int NUM_BANKS      = DEFAULT_NUM_BANKS,
  parameter int LINES_PER_BANK = DEFAULT_LINES_PER_BANK
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      fencei_valid_i,
  input  addr_t     wb_pc_i,
  input  logic      data_req_i,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  logic      wbuf_empty_i,

  input  logic      fill_valid_i,
  input  bank_idx_t fill_bank_i,
  input  line_idx_t fill_line_i,

  output logic      flush_req_o,
  output logic      flush_ack_o,
  output logic      retire_o,
  output logic      fetch_req_o,
  output addr_t     fetch_addr_o,
  output logic      data_block_o,
  output logic      busy_o
);

  logic                      flush_req;
  logic                      flush_ack;
  logic [NUM_BANKS-1:0]      fill_en;
  logic [NUM_BANKS-1:0]      bank_done;
  logic [LINES_PER_BANK-1:0] bank_valid [NUM_BANKS];
  logic                      any_valid;

  fencei_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fencei_valid_i (fencei_valid_i),
    .wb_pc_i        (wb_pc_i),
    .data_req_i     (data_req_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .wbuf_empty_i   (wbuf_empty_i),
    .flush_ack_i    (flush_ack),
    .flush_req_o    (flush_req),
    .retire_o       (retire_o),
    .fetch_req_o    (fetch_req_o),
    .fetch_addr_o   (fetch_addr_o),
    .data_block_o   (data_block_o),
    .busy_o         (busy_o)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    assign fill_en[b] = fill_valid_i && (fill_bank_i == bank_idx_t'(b));

    icache_bank_flush #(
      .LINES_PER_BANK (LINES_PER_BANK)
    ) u_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .fill_en_i   (fill_en[b]),
      .fill_line_i (fill_line_i),
      .flush_req_i (flush_req),
      .done_o      (bank_done[b]),
      .valid_o     (bank_valid[b])
    );
  end

  flush_ack_merge #(
    .NUM_BANKS (NUM_BANKS)
  ) u_merge (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_req_i (flush_req),
    .bank_done_i (bank_done),
    .flush_ack_o (flush_ack)
  );

  assign flush_req_o = flush_req;
  assign flush_ack_o = flush_ack;

  // Any line still valid in any bank
  always_comb begin
    any_valid = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      any_valid = any_valid | (|bank_valid[b]);
    end
  end

  a_ack_cache_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_ack |-> !any_valid
  ) else $error("flush acknowledged with valid lines left in the cache");

endmodule

/* flush_ack_merge.sv */
// ########################################################
// Collects the per-bank done pulses of one flush.
// Each bank's done is held until the request drops. The
// acknowledge pulses once, the cycle after the last bank
// has reported.
// ########################################################

`timescale 1ns/1ps

module flush_ack_merge #(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 flush_req_i,
  input  logic [NUM_BANKS-1:0] bank_done_i,

  output logic                 flush_ack_o
);

  logic [NUM_BANKS-1:0] sticky_q;
  logic                 ack_sent_q;

  // Sticky done bits, only live while the request is up
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sticky_q <= '0;
    end else if (!flush_req_i) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= sticky_q | bank_done_i;
    end
  end

  // One acknowledge per request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sent_q <= 1'b0;
    end else if (!flush_req_i) begin
      ack_sent_q <= 1'b0;
    end else if (flush_ack_o) begin
      ack_sent_q <= 1'b1;
    end
  end

  assign flush_ack_o = flush_req_i && (&sticky_q) && !ack_sent_q;

  a_ack_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_ack_o |=> !flush_ack_o
  ) else $error("flush acknowledge high for two cycles");

endmodule

/* icache_bank_flush.sv */
// ########################################################
// One instruction cache bank, valid bits only.
// A fill strobe sets a line valid. A rising flush request
// starts a walk that clears the lowest valid line each
// cycle and pulses done once the bank is empty.
// ########################################################

`timescale 1ns/1ps

module icache_bank_flush import fencei_pkg::*; #(
  parameter int LINES_PER_BANK = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      fill_en_i,
  input  line_idx_t                 fill_line_i,

  input  logic                      flush_req_i,

  output logic                      done_o,
  output logic [LINES_PER_BANK-1:0] valid_o
);

  logic [LINES_PER_BANK-1:0] valid_q, valid_d;
  logic [LINES_PER_BANK-1:0] valid_cleared;
  logic                      req_q;
  logic                      walk_q, walk_d;
  logic                      done_q, done_d;
  logic                      walk_start;
  logic                      walk_active;

  assign walk_start  = flush_req_i && !req_q;
  assign walk_active = flush_req_i && (walk_start || walk_q);

  // Drop the lowest set bit
  assign valid_cleared = valid_q & (valid_q - 1'b1);

  always_comb begin
    valid_d = valid_q;
    walk_d  = walk_q;
    done_d  = 1'b0;

    if (walk_active) begin
      valid_d = valid_cleared;
      // Last line gone, or bank was empty to begin with
      if (valid_cleared == '0) begin
        walk_d = 1'b0;
        done_d = 1'b1;
      end else begin
        walk_d = 1'b1;
      end
    end else if (!flush_req_i) begin
      walk_d = 1'b0;
      if (fill_en_i) begin
        for (int i = 0; i < LINES_PER_BANK; i++) begin
          if (fill_line_i == line_idx_t'(i)) begin
            valid_d[i] = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      req_q   <= 1'b0;
      walk_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      valid_q <= valid_d;
      req_q   <= flush_req_i;
      walk_q  <= walk_d;
      done_q  <= done_d;
    end
  end

  assign done_o  = done_q;
  assign valid_o = valid_q;

  a_done_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |-> (valid_q == '0)
  ) else $error("bank done with valid lines remaining");

endmodule

/* fencei_ctrl.sv */
// ########################################################
// Fence.i sequencer for the writeback stage.
// Holds the instruction until the data bus and the write
// buffer are idle, raises the cache flush request, then
// retires and fetches the next aligned word once the flush
// is acknowledged.
// ########################################################

`timescale 1ns/1ps

module fencei_ctrl import fencei_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,

  input  logic  fencei_valid_i,
  input  addr_t wb_pc_i,

  input  logic  data_req_i,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  input  logic  wbuf_empty_i,

  input  logic  flush_ack_i,

  output logic  flush_req_o,
  output logic  retire_o,
  output logic  fetch_req_o,
  output addr_t fetch_addr_o,
  output logic  data_block_o,
  output logic  busy_o
);

  localparam int OUTS_W = $clog2(OUTS_MAX + 1);

  fencei_state_e state_q, state_d;

  logic [OUTS_W-1:0] outs_q;
  logic              bus_granted;
  logic              count_up;
  logic              count_down;
  logic              bus_idle;

  addr_t pc_q;

  // Outstanding data transaction counter
  assign bus_granted = data_req_i && data_gnt_i;
  assign count_up    = bus_granted && !data_rvalid_i && (outs_q != OUTS_W'(OUTS_MAX));
  assign count_down  = data_rvalid_i && !bus_granted && (outs_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outs_q <= '0;
    end else if (count_up) begin
      outs_q <= outs_q + 1'b1;
    end else if (count_down) begin
      outs_q <= outs_q - 1'b1;
    end
  end

  // A grant in this very cycle would leave one outstanding next cycle
  assign bus_idle = (outs_q == '0) && wbuf_empty_i && !bus_granted;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (fencei_valid_i) begin
          state_d = bus_idle ? FLUSH : WAIT_BUS;
        end
      end
      WAIT_BUS: begin
        if (bus_idle) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        if (flush_ack_i) begin
          state_d = REDIRECT;
        end
      end
      REDIRECT: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // PC of the fence.i, captured on acceptance
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && fencei_valid_i) begin
      pc_q <= wb_pc_i;
    end
  end

  assign flush_req_o  = (state_q == FLUSH);
  assign data_block_o = (state_q == WAIT_BUS) || (state_q == FLUSH);
  assign busy_o       = (state_q != IDLE);
  assign retire_o     = (state_q == REDIRECT);
  assign fetch_req_o  = (state_q == REDIRECT);

  // Next word after the fence.i, wraps at the top of memory
  assign fetch_addr_o = {pc_q[31:2], 2'b00} + 32'd4;

  a_req_stay_high: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_req_o && !flush_ack_i |=> flush_req_o
  ) else $error("flush request dropped before acknowledge");

  a_req_drop_after_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_req_o && flush_ack_i |=> !flush_req_o
  ) else $error("flush request still high after acknowledge");

  a_req_bus_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(flush_req_o) |-> (outs_q == '0)
  ) else $error("flush request raised with data transactions outstanding");

  a_no_data_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_req_o |-> !data_req_i
  ) else $error("data request seen during flush");

endmodule

/* fencei_pkg.sv */
// ########################################################
// Shared types and constants for the fence.i flush path.
// Address, bank and line index types, the controller state
// encoding and the outstanding transaction limit. Modules
// take what they need through a wildcard import.
// ########################################################

package fencei_pkg;

  // Instruction address
  typedef logic [31:0] addr_t;

  // Line index within one bank, wide enough for 16 lines
  typedef logic [3:0] line_idx_t;

  // Bank number, up to 4 banks
  typedef logic [1:0] bank_idx_t;

  // Default geometry used by the top level
  localparam int DEFAULT_NUM_BANKS      = 4;
  localparam int DEFAULT_LINES_PER_BANK = 16;

  // Saturation point of the outstanding data bus counter
  localparam int OUTS_MAX = 4;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE,
    // Waiting for the data bus and write buffer to drain
    WAIT_BUS,
    // Flush request held high
    FLUSH,
    // Retire and fetch of the next word
    REDIRECT
  } fencei_state_e;

endpackage
